/* design/pixelPkg.sv */
`default_nettype none

package pixelPkg;

    ////////////////////////////////////////
    // Data widths
    ////////////////////////////////////////
    typedef logic [7:0]  subPixel_t;
    // RGBA with R in the top byte
    typedef logic [31:0] pixel_t;
    typedef logic [10:0] screenPos_t;
    typedef logic [13:0] fbIndex_t;
    // Q16.16
    typedef logic [31:0] depth_t;
    // S16.15
    typedef logic [31:0] texCoord_t;
    // T row in the upper half and S column in the lower half
    typedef logic [13:0] texAddr_t;
    typedef logic [63:0] lutBeat_t;
    typedef logic [7:0]  fogFactor_t;
    typedef logic [4:0]  fogIndex_t;
    typedef logic [1:0]  beatCount_t;

    // Texture environment mode where code 3 behaves like REPLACE
    typedef logic [1:0]  texEnvMode_t;
    localparam texEnvMode_t REPLACE  = 2'd0;
    localparam texEnvMode_t MODULATE = 2'd1;
    localparam texEnvMode_t ADD      = 2'd2;

    typedef enum logic [1:0] {Load, Commit, Discard} loaderState_t;

    ////////////////////////////////////////
    // Sizes, feature bits and latencies
    ////////////////////////////////////////
    localparam int FOG_LUT_ENTRIES  = 32;
    localparam int FACTORS_PER_BEAT = 8;
    localparam int LUT_BEATS        = 4;
    localparam int FEATURE_TEX_POS  = 0;
    localparam int FEATURE_FOG_POS  = 1;
    localparam int TEX_LATENCY      = 3;
    localparam int FOG_LATENCY      = 2;

endpackage

`default_nettype wire

/* design/beatCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module beatCounter
#(
    parameter int BEATS = 4
)
(
    input  wire                      aclk,
    input  wire                      reset,
    input  wire                      advance,
    input  wire                      clear,
    output pixelPkg::beatCount_t     count,
    output logic                     overflow
);

    always_ff @(posedge aclk)
    begin
        if (reset || clear)
        begin
            count    <= '0;
            overflow <= 1'b0;
        end
        else if (advance)
        begin
            count <= count + 1'b1;
            // A full load went by without a last, so the load runs long
            if (count == pixelPkg::beatCount_t'(BEATS - 1))
            begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/fogLutLoader.sv */
`timescale 1ns/1ps
`default_nettype none

module fogLutLoader
#(
    parameter int BEATS = 4
)
(
    input  wire                      aclk,
    input  wire                      reset,
    input  wire                      lutValid,
    input  wire                      lutLast,
    output logic                     lutReady,
    input  wire pixelPkg::beatCount_t beatCount,
    input  wire                      overflow,
    output logic                     countAdvance,
    output logic                     countClear,
    output logic                     beatWrite,
    output logic                     commit
);

    pixelPkg::loaderState_t state;
    pixelPkg::loaderState_t nextState;
    logic                   loadComplete;

    assign beatWrite    = lutValid && lutReady;
    assign countAdvance = beatWrite;
    assign countClear   = beatWrite && lutLast;
    assign commit       = (state == pixelPkg::Commit);

    // Only a last on the final beat of a load that did not run long
    assign loadComplete = (beatCount == pixelPkg::beatCount_t'(BEATS - 1)) && !overflow;

    always_comb
    begin
        nextState = state;
        case (state)
            pixelPkg::Load:
            begin
                if (countClear)
                begin
                    nextState = loadComplete ? pixelPkg::Commit : pixelPkg::Discard;
                end
            end
            default:
                nextState = pixelPkg::Load;
        endcase
    end

    // Ready is only high in Load once reset has ended
    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            state    <= pixelPkg::Load;
            lutReady <= 1'b0;
        end
        else
        begin
            state    <= nextState;
            lutReady <= (nextState == pixelPkg::Load);
        end
    end

endmodule

`default_nettype wire

/* design/fogTable.sv */
`timescale 1ns/1ps
`default_nettype none

module fogTable
(
    input  wire                        aclk,
    input  wire                        reset,
    input  wire                        beatWrite,
    input  wire pixelPkg::beatCount_t  beatNum,
    input  wire pixelPkg::lutBeat_t    lutData,
    input  wire                        commit,
    input  wire pixelPkg::fogIndex_t   readIndex,
    output pixelPkg::fogFactor_t       factor
);

    pixelPkg::fogFactor_t shadowTable [pixelPkg::FOG_LUT_ENTRIES];
    pixelPkg::fogFactor_t activeTable [pixelPkg::FOG_LUT_ENTRIES];

    // Factor i of a beat sits in byte i of the word
    always_ff @(posedge aclk)
    begin
        if (beatWrite)
        begin
            for (int i = 0; i < pixelPkg::FACTORS_PER_BEAT; i++)
            begin
                shadowTable[{beatNum, 3'(i)}] <= lutData[i * 8 +: 8];
            end
        end
    end

    // Active table starts as "no fog" everywhere
    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            for (int i = 0; i < pixelPkg::FOG_LUT_ENTRIES; i++)
            begin
                activeTable[i] <= 8'hff;
            end
        end
        else if (commit)
        begin
            activeTable <= shadowTable;
        end
    end

    always_ff @(posedge aclk)
    begin
        factor <= activeTable[readIndex];
    end

endmodule

`default_nettype wire

/* design/texEnvUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module texEnvUnit
(
    input  wire                          aclk,
    input  wire                          reset,
    input  wire                          enable,
    input  wire pixelPkg::texEnvMode_t   mode,
    input  wire                          inValid,
    input  wire pixelPkg::texCoord_t     texS,
    input  wire pixelPkg::texCoord_t     texT,
    input  wire pixelPkg::pixel_t        primaryColor,
    input  wire pixelPkg::depth_t        depthIn,
    output pixelPkg::texAddr_t           texelAddr,
    input  wire pixelPkg::pixel_t        texelData,
    output pixelPkg::pixel_t             color,
    output pixelPkg::depth_t             depthOut
);

    pixelPkg::pixel_t      stage1Color;
    pixelPkg::pixel_t      stage2Color;
    pixelPkg::texEnvMode_t stage1Mode;
    pixelPkg::texEnvMode_t stage2Mode;
    logic                  stage1Enable;
    logic                  stage2Enable;
    pixelPkg::depth_t      depthPipe [pixelPkg::TEX_LATENCY];

    function automatic pixelPkg::subPixel_t combine(
        input pixelPkg::texEnvMode_t envMode,
        input pixelPkg::subPixel_t   texel,
        input pixelPkg::subPixel_t   prim
    );
        logic [15:0] product;
        logic [8:0]  sum;
        product = texel * prim;
        sum     = texel + prim;
        case (envMode)
            pixelPkg::MODULATE: return product[15:8];
            pixelPkg::ADD:      return sum[8] ? 8'hff : sum[7:0];
            default:            return texel;
        endcase
    endfunction

    ////////////////////////////////////////
    // Stage 1 and 2 addressing
    ////////////////////////////////////////
    // Repeat wrap on 128x128 falls out of taking 7 integer bits
    always_ff @(posedge aclk)
    begin
        if (inValid)
        begin
            texelAddr <= {texT[21:15], texS[21:15]};
        end
        stage1Color <= primaryColor;
        stage2Color <= stage1Color;
    end

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            stage1Enable <= 1'b0;
            stage2Enable <= 1'b0;
            stage1Mode   <= pixelPkg::REPLACE;
            stage2Mode   <= pixelPkg::REPLACE;
        end
        else
        begin
            stage1Enable <= enable;
            stage2Enable <= stage1Enable;
            stage1Mode   <= mode;
            stage2Mode   <= stage1Mode;
        end
    end

    ////////////////////////////////////////
    // Stage 3 combine
    ////////////////////////////////////////
    // Texel comes back from the memory read register during stage 2
    always_ff @(posedge aclk)
    begin
        if (stage2Enable)
        begin
            for (int ch = 0; ch < 4; ch++)
            begin
                color[ch * 8 +: 8] <= combine(stage2Mode, texelData[ch * 8 +: 8],
                                              stage2Color[ch * 8 +: 8]);
            end
        end
        else
        begin
            color <= stage2Color;
        end
    end

    // Depth keeps pace with the color for the fog stage
    always_ff @(posedge aclk)
    begin
        depthPipe[0] <= depthIn;
        for (int i = 1; i < pixelPkg::TEX_LATENCY; i++)
        begin
            depthPipe[i] <= depthPipe[i - 1];
        end
    end

    assign depthOut = depthPipe[pixelPkg::TEX_LATENCY - 1];

endmodule

`default_nettype wire

/* design/fogBlend.sv */
`timescale 1ns/1ps
`default_nettype none

module fogBlend
(
    input  wire                         aclk,
    input  wire                         reset,
    input  wire                         enable,
    input  wire pixelPkg::pixel_t       fogColor,
    input  wire pixelPkg::depth_t       depth,
    input  wire pixelPkg::pixel_t       colorIn,
    output pixelPkg::fogIndex_t         readIndex,
    input  wire pixelPkg::fogFactor_t   factor,
    output pixelPkg::pixel_t            colorOut
);

    pixelPkg::pixel_t stage1Color;
    logic             stage1Enable;
    logic [15:0]      mix [4];

    // Integer part of depth where anything past the table uses the last entry
    assign readIndex = (depth[31:21] != '0) ? 5'd31 : depth[20:16];

    always_ff @(posedge aclk)
    begin
        stage1Color <= colorIn;
        if (reset)
        begin
            stage1Enable <= 1'b0;
        end
        else
        begin
            stage1Enable <= enable;
        end
    end

    // f * c + (255 - f) * fog never exceeds 255 * 255
    always_comb
    begin
        for (int ch = 0; ch < 4; ch++)
        begin
            mix[ch] = factor * stage1Color[ch * 8 +: 8]
                    + (8'd255 - factor) * fogColor[ch * 8 +: 8];
        end
    end

    always_ff @(posedge aclk)
    begin
        for (int ch = 0; ch < 4; ch++)
        begin
            colorOut[ch * 8 +: 8] <= stage1Enable ? mix[ch][15:8] : stage1Color[ch * 8 +: 8];
        end
    end

endmodule

`default_nettype wire

/* design/delayLine.sv */
`timescale 1ns/1ps
`default_nettype none

module delayLine
#(
    parameter int DELAY = 5
)
(
    input  wire                          aclk,
    input  wire                          reset,
    input  wire                          inValid,
    input  wire                          inLast,
    input  wire                          inKeep,
    input  wire pixelPkg::fbIndex_t      inIndex,
    input  wire pixelPkg::screenPos_t    inPosX,
    input  wire pixelPkg::screenPos_t    inPosY,
    input  wire pixelPkg::depth_t        inDepth,
    output logic                         outValid,
    output logic                         outLast,
    output logic                         outKeep,
    output pixelPkg::fbIndex_t           outIndex,
    output pixelPkg::screenPos_t         outPosX,
    output pixelPkg::screenPos_t         outPosY,
    output pixelPkg::depth_t             outDepth
);

    logic [DELAY-1:0]      validPipe;
    logic [DELAY-1:0]      lastPipe;
    logic [DELAY-1:0]      keepPipe;
    pixelPkg::fbIndex_t    indexPipe [DELAY];
    pixelPkg::screenPos_t  posXPipe  [DELAY];
    pixelPkg::screenPos_t  posYPipe  [DELAY];
    pixelPkg::depth_t      depthPipe [DELAY];

    always_ff @(posedge aclk)
    begin
        if (reset)
        begin
            validPipe <= '0;
        end
        else
        begin
            validPipe <= {validPipe[DELAY-2:0], inValid};
        end
    end

    // Payload shifts along with stage 0 taking the new fragment
    always_ff @(posedge aclk)
    begin
        lastPipe     <= {lastPipe[DELAY-2:0], inLast};
        keepPipe     <= {keepPipe[DELAY-2:0], inKeep};
        indexPipe[0] <= inIndex;
        posXPipe[0]  <= inPosX;
        posYPipe[0]  <= inPosY;
        depthPipe[0] <= inDepth;
        for (int i = 1; i < DELAY; i++)
        begin
            indexPipe[i] <= indexPipe[i - 1];
            posXPipe[i]  <= posXPipe[i - 1];
            posYPipe[i]  <= posYPipe[i - 1];
            depthPipe[i] <= depthPipe[i - 1];
        end
    end

    assign outValid = validPipe[DELAY-1];
    assign outLast  = lastPipe[DELAY-1];
    assign outKeep  = keepPipe[DELAY-1];
    assign outIndex = indexPipe[DELAY-1];
    assign outPosX  = posXPipe[DELAY-1];
    assign outPosY  = posYPipe[DELAY-1];
    assign outDepth = depthPipe[DELAY-1];

endmodule

`default_nettype wire

/* design/pixelPipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module pixelPipeline
#(
    parameter int LUT_BEATS = pixelPkg::LUT_BEATS
)
(
    input  wire                          aclk,
    input  wire                          reset,

    // Configuration
    input  wire [31:0]                   confFeatureEnable,
    input  wire pixelPkg::texEnvMode_t   confTexEnvMode,
    input  wire pixelPkg::pixel_t        confFogColor,

    // Fog LUT stream
    input  wire                          lutValid,
    input  wire                          lutLast,
    input  wire pixelPkg::lutBeat_t      lutData,
    output logic                         lutReady,

    // Fragment stream, no back-pressure
    input  wire                          fragValid,
    input  wire                          fragLast,
    input  wire                          fragKeep,
    input  wire pixelPkg::fbIndex_t      fragIndex,
    input  wire pixelPkg::screenPos_t    fragPosX,
    input  wire pixelPkg::screenPos_t    fragPosY,
    input  wire pixelPkg::depth_t        fragDepth,
    input  wire pixelPkg::texCoord_t     fragTexS,
    input  wire pixelPkg::texCoord_t     fragTexT,
    input  wire pixelPkg::pixel_t        fragColor,

    // Texture memory, synchronous read
    output pixelPkg::texAddr_t           texelAddr,
    input  wire pixelPkg::pixel_t        texelData,

    // Framebuffer
    output pixelPkg::pixel_t             fbColor,
    output pixelPkg::fbIndex_t           fbIndex,
    output pixelPkg::screenPos_t         fbPosX,
    output pixelPkg::screenPos_t         fbPosY,
    output pixelPkg::depth_t             fbDepth,
    output logic                         fbValid,
    output logic                         fbLast,
    output logic                         fbKeep
);

    localparam int PIPE_LATENCY = pixelPkg::TEX_LATENCY + pixelPkg::FOG_LATENCY;

    ////////////////////////////////////////
    // Fog LUT loading
    ////////////////////////////////////////
    pixelPkg::beatCount_t beatCount;
    logic                 overflow;
    logic                 countAdvance;
    logic                 countClear;
    logic                 beatWrite;
    logic                 commit;

    fogLutLoader #(.BEATS(LUT_BEATS)) loader_i (
        .aclk(aclk), .reset(reset),
        .lutValid(lutValid), .lutLast(lutLast), .lutReady(lutReady),
        .beatCount(beatCount), .overflow(overflow),
        .countAdvance(countAdvance), .countClear(countClear),
        .beatWrite(beatWrite), .commit(commit)
    );

    beatCounter #(.BEATS(LUT_BEATS)) counter_i (
        .aclk(aclk), .reset(reset),
        .advance(countAdvance), .clear(countClear),
        .count(beatCount), .overflow(overflow)
    );

    pixelPkg::fogIndex_t  fogIndex;
    pixelPkg::fogFactor_t fogFactor;

    fogTable table_i (
        .aclk(aclk), .reset(reset),
        .beatWrite(beatWrite), .beatNum(beatCount), .lutData(lutData),
        .commit(commit), .readIndex(fogIndex), .factor(fogFactor)
    );

    ////////////////////////////////////////
    // Color path
    ////////////////////////////////////////
    pixelPkg::pixel_t texColor;
    pixelPkg::depth_t texDepth;

    texEnvUnit tex_i (
        .aclk(aclk), .reset(reset),
        .enable(confFeatureEnable[pixelPkg::FEATURE_TEX_POS]), .mode(confTexEnvMode),
        .inValid(fragValid), .texS(fragTexS), .texT(fragTexT),
        .primaryColor(fragColor), .depthIn(fragDepth),
        .texelAddr(texelAddr), .texelData(texelData),
        .color(texColor), .depthOut(texDepth)
    );

    fogBlend fog_i (
        .aclk(aclk), .reset(reset),
        .enable(confFeatureEnable[pixelPkg::FEATURE_FOG_POS]), .fogColor(confFogColor),
        .depth(texDepth), .colorIn(texColor),
        .readIndex(fogIndex), .factor(fogFactor), .colorOut(fbColor)
    );

    // Metadata rides alongside for the whole color path
    delayLine #(.DELAY(PIPE_LATENCY)) meta_i (
        .aclk(aclk), .reset(reset),
        .inValid(fragValid), .inLast(fragLast), .inKeep(fragKeep),
        .inIndex(fragIndex), .inPosX(fragPosX), .inPosY(fragPosY), .inDepth(fragDepth),
        .outValid(fbValid), .outLast(fbLast), .outKeep(fbKeep),
        .outIndex(fbIndex), .outPosX(fbPosX), .outPosY(fbPosY), .outDepth(fbDepth)
    );

endmodule

`default_nettype wire

/* tb/fogLutLoader_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module fogLutLoaderProperties
(
    input wire                         aclk,
    input wire                         reset,
    input wire                         lutValid,
    input wire                         lutLast,
    input wire                         lutReady,
    input wire                         beatWrite,
    input wire                         commit,
    input wire pixelPkg::loaderState_t state
);

    // Loader leaves Load for one cycle after every last beat
    readyDropsAfterLast: assert property (
        @(posedge aclk) disable iff (reset)
        (lutValid && lutReady && lutLast) |=> !lutReady
    ) else $error("lutReady stayed high after an accepted last beat");

    commitFollowsLast: assert property (
        @(posedge aclk) disable iff (reset)
        commit |-> $past(lutValid && lutReady && lutLast)
    ) else $error("commit without an accepted last beat one cycle before");

    // No beat lands while the loader decides commit or discard
    writeOnlyInLoad: assert property (
        @(posedge aclk) disable iff (reset)
        beatWrite |-> (state == pixelPkg::Load)
    ) else $error("beatWrite outside the Load state");

endmodule

bind fogLutLoader fogLutLoaderProperties props_i (
    .aclk(aclk), .reset(reset),
    .lutValid(lutValid), .lutLast(lutLast), .lutReady(lutReady),
    .beatWrite(beatWrite), .commit(commit), .state(state)
);

`default_nettype wire

/* tb/pixelPipelineTb.sv */
`timescale 1ns/1ps
`default_nettype none

module pixelPipelineTb;

    localparam int NUM_ROWS       = 18;
    localparam int LOAD_BEATS     = 19;
    localparam int TIMEOUT_CYCLES = 20 * (NUM_ROWS + LOAD_BEATS) + 200;

    typedef struct {
        pixelPkg::texEnvMode_t mode;
        logic [31:0]           enables;
        pixelPkg::texCoord_t   s;
        pixelPkg::texCoord_t   t;
        pixelPkg::depth_t      depth;
        pixelPkg::pixel_t      color;
        pixelPkg::fbIndex_t    index;
        pixelPkg::screenPos_t  posX;
        pixelPkg::screenPos_t  posY;
        logic                  last;
        logic                  keep;
        pixelPkg::pixel_t      expected;
    } rowEntry_t;

    logic                  aclk = 1'b0;
    logic                  reset;
    logic [31:0]           confFeatureEnable;
    pixelPkg::texEnvMode_t confTexEnvMode;
    pixelPkg::pixel_t      confFogColor;
    logic                  lutValid;
    logic                  lutLast;
    pixelPkg::lutBeat_t    lutData;
    logic                  lutReady;
    logic                  fragValid;
    logic                  fragLast;
    logic                  fragKeep;
    pixelPkg::fbIndex_t    fragIndex;
    pixelPkg::screenPos_t  fragPosX;
    pixelPkg::screenPos_t  fragPosY;
    pixelPkg::depth_t      fragDepth;
    pixelPkg::texCoord_t   fragTexS;
    pixelPkg::texCoord_t   fragTexT;
    pixelPkg::pixel_t      fragColor;
    pixelPkg::texAddr_t    texelAddr;
    pixelPkg::pixel_t      texelData;
    pixelPkg::pixel_t      fbColor;
    pixelPkg::fbIndex_t    fbIndex;
    pixelPkg::screenPos_t  fbPosX;
    pixelPkg::screenPos_t  fbPosY;
    pixelPkg::depth_t      fbDepth;
    logic                  fbValid;
    logic                  fbLast;
    logic                  fbKeep;

    rowEntry_t             rows [NUM_ROWS];
    int                    rowCount = 0;
    pixelPkg::fogFactor_t  goodTable [pixelPkg::FOG_LUT_ENTRIES];
    pixelPkg::lutBeat_t    loadBeats [8];
    pixelPkg::texAddr_t    addrHeld = '0;
    int                    dueQ [$];
    int                    rowQ [$];
    int                    cycleNum = 0;
    int                    checkCount = 0;
    int                    errorCount = 0;
    logic                  checkOn = 1'b0;

    pixelPipeline dut_i (.*);

    always #2 aclk = ~aclk;

    always @(posedge aclk)
    begin
        cycleNum <= cycleNum + 1;
        if (cycleNum >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Texture memory with one cycle of read latency
    always @(posedge aclk)
    begin
        #1;
        texelData = texelOf(addrHeld);
        addrHeld  = texelAddr;
    end

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic pixelPkg::pixel_t texelOf(input pixelPkg::texAddr_t addr);
        return {addr[7:0], ~addr[7:0], addr[13:8], 2'b01, 2'b11, addr[13:8]};
    endfunction

    function automatic pixelPkg::pixel_t texturedColor(input rowEntry_t r);
        pixelPkg::pixel_t texel;
        pixelPkg::pixel_t result;
        int               sInt;
        int               tInt;
        int               sWrap;
        int               tWrap;
        int               tx;
        int               pc;
        // Integer parts of the S16.15 coordinates with repeat wrap
        sInt  = $signed(r.s) >>> 15;
        tInt  = $signed(r.t) >>> 15;
        sWrap = ((sInt % 128) + 128) % 128;
        tWrap = ((tInt % 128) + 128) % 128;
        texel = texelOf(14'(tWrap * 128 + sWrap));
        if (!r.enables[pixelPkg::FEATURE_TEX_POS])
        begin
            return r.color;
        end
        for (int ch = 0; ch < 4; ch++)
        begin
            tx = texel[ch * 8 +: 8];
            pc = r.color[ch * 8 +: 8];
            case (r.mode)
                pixelPkg::MODULATE: result[ch * 8 +: 8] = 8'((tx * pc) >> 8);
                pixelPkg::ADD:      result[ch * 8 +: 8] = (tx + pc > 255) ? 8'd255 : 8'(tx + pc);
                default:            result[ch * 8 +: 8] = 8'(tx);
            endcase
        end
        return result;
    endfunction

    function automatic pixelPkg::pixel_t foggedColor(input rowEntry_t r,
                                                     input pixelPkg::pixel_t c);
        pixelPkg::pixel_t result;
        int               idx;
        int               f;
        int               cc;
        int               fc;
        if (!r.enables[pixelPkg::FEATURE_FOG_POS])
        begin
            return c;
        end
        // Integer part of Q16.16 depth clamped to the last entry
        idx = (r.depth[31:16] > 31) ? 31 : int'(r.depth[20:16]);
        f   = goodTable[idx];
        for (int ch = 0; ch < 4; ch++)
        begin
            cc = c[ch * 8 +: 8];
            fc = confFogColor[ch * 8 +: 8];
            result[ch * 8 +: 8] = 8'((f * cc + (255 - f) * fc) >> 8);
        end
        return result;
    endfunction

    ////////////////////////////////////////
    // Checks and stimulus helpers
    ////////////////////////////////////////
    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic addRow(input pixelPkg::texEnvMode_t mode, input logic [31:0] enables,
                          input int sInt, input int tInt, input pixelPkg::depth_t depth,
                          input pixelPkg::pixel_t color, input logic last);
        rowEntry_t r;
        r.mode    = mode;
        r.enables = enables;
        // Nonzero fraction bits that addressing must ignore
        r.s       = (pixelPkg::texCoord_t'(sInt) << 15) | 32'h2a55;
        r.t       = (pixelPkg::texCoord_t'(tInt) << 15) | 32'h1c3;
        r.depth   = depth;
        r.color   = color;
        r.index   = 14'(rowCount * 37 + 5);
        r.posX    = 11'(rowCount * 13);
        r.posY    = 11'(1000 - rowCount * 7);
        r.last    = last;
        r.keep    = rowCount[0];
        rows[rowCount] = r;
        rowCount++;
    endtask

    task automatic applyRow(input int i);
        confFeatureEnable = rows[i].enables;
        confTexEnvMode    = rows[i].mode;
        fragValid         = 1'b1;
        fragLast          = rows[i].last;
        fragKeep          = rows[i].keep;
        fragIndex         = rows[i].index;
        fragPosX          = rows[i].posX;
        fragPosY          = rows[i].posY;
        fragDepth         = rows[i].depth;
        fragTexS          = rows[i].s;
        fragTexT          = rows[i].t;
        fragColor         = rows[i].color;
        dueQ.push_back(cycleNum + 5);
        rowQ.push_back(i);
    endtask

    task automatic drainPipe();
        while (rowQ.size() != 0)
        begin
            @(posedge aclk);
            #1;
        end
    endtask

    // Config is only changed with the pipeline empty
    task automatic runRows(input int first, input int last);
        for (int i = first; i <= last; i++)
        begin
            if (i != first && (rows[i].mode != rows[i - 1].mode ||
                               rows[i].enables != rows[i - 1].enables))
            begin
                fragValid = 1'b0;
                drainPipe();
            end
            applyRow(i);
            @(posedge aclk);
            #1;
        end
        fragValid = 1'b0;
        drainPipe();
    endtask

    task automatic sendLoad(input int numBeats, input int lastAt);
        logic accepted;
        for (int b = 0; b < numBeats; b++)
        begin
            lutValid = 1'b1;
            lutData  = loadBeats[b];
            lutLast  = (b == lastAt);
            accepted = 1'b0;
            while (!accepted)
            begin
                accepted = lutReady;
                @(posedge aclk);
                #1;
            end
        end
        lutValid = 1'b0;
        lutLast  = 1'b0;
        // Ready comes back once the table decision has landed
        while (!lutReady)
        begin
            @(posedge aclk);
            #1;
        end
    endtask

    // Every output cycle is either the due row or idle
    always @(posedge aclk)
    begin : outputCheck
        int r;
        #1;
        if (checkOn)
        begin
            if (dueQ.size() != 0 && dueQ[0] == cycleNum)
            begin
                r = rowQ.pop_front();
                void'(dueQ.pop_front());
                checkValue("fbValid", fbValid, 1'b1);
                checkValue("fbColor", fbColor, rows[r].expected);
                checkValue("fbIndex", fbIndex, rows[r].index);
                checkValue("fbPosX", fbPosX, rows[r].posX);
                checkValue("fbPosY", fbPosY, rows[r].posY);
                checkValue("fbDepth", fbDepth, rows[r].depth);
                checkValue("fbLast", fbLast, rows[r].last);
                checkValue("fbKeep", fbKeep, rows[r].keep);
            end
            else
            begin
                checkValue("fbValid", fbValid, 1'b0);
            end
        end
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial
    begin
        reset             = 1'b1;
        confFeatureEnable = '0;
        confTexEnvMode    = pixelPkg::REPLACE;
        confFogColor      = 32'h8040c0ff;
        lutValid          = 1'b0;
        lutLast           = 1'b0;
        lutData           = '0;
        fragValid         = 1'b0;
        fragLast          = 1'b0;
        fragKeep          = 1'b0;
        fragIndex         = '0;
        fragPosX          = '0;
        fragPosY          = '0;
        fragDepth         = '0;
        fragTexS          = '0;
        fragTexT          = '0;
        fragColor         = '0;
        texelData         = '0;

        void'($urandom(32'h4ee8));
        for (int i = 0; i < pixelPkg::FOG_LUT_ENTRIES; i++)
        begin
            goodTable[i] = 8'($urandom);
        end

        // Fog off with one group per mode
        addRow(pixelPkg::REPLACE, 32'h1, 5, 9, 32'h0003_0000, 32'h11223344, 1'b1);
        addRow(pixelPkg::MODULATE, 32'h1, 200, 3, 32'h0010_8000, 32'hff80_40c0, 1'b0);
        addRow(pixelPkg::MODULATE, 32'h1, -3, 127, 32'h0001_0000, 32'h7f7f_7f7f, 1'b0);
        addRow(pixelPkg::MODULATE, 32'h1, 64, 64, 32'h0040_0000, 32'h0102_0304, 1'b0);
        addRow(pixelPkg::MODULATE, 32'h1, 1, 130, 32'h0000_1234, 32'hffff_ffff, 1'b1);
        addRow(pixelPkg::ADD, 32'h1, 100, 27, 32'h0002_0000, 32'h80f0_1020, 1'b0);
        addRow(pixelPkg::ADD, 32'h1, -50, 70, 32'h0005_0000, 32'h0000_ff01, 1'b1);
        addRow(2'd3, 32'h1, 33, 44, 32'h0006_0000, 32'h5566_7788, 1'b1);
        addRow(pixelPkg::MODULATE, 32'h0, 12, 12, 32'h0007_0000, 32'hdead_beef, 1'b1);
        // Fog on after the good load
        addRow(pixelPkg::REPLACE, 32'h3, 10, 20, 32'h0000_8000, 32'h1020_3040, 1'b0);
        addRow(pixelPkg::REPLACE, 32'h3, 11, 21, 32'h0007_0000, 32'h1020_3040, 1'b0);
        addRow(pixelPkg::REPLACE, 32'h3, 12, 22, 32'h0014_4000, 32'h1020_3040, 1'b0);
        addRow(pixelPkg::REPLACE, 32'h3, 13, 23, 32'h001f_0000, 32'h1020_3040, 1'b0);
        addRow(pixelPkg::REPLACE, 32'h3, 14, 24, 32'h0064_0000, 32'h1020_3040, 1'b1);
        addRow(pixelPkg::MODULATE, 32'h2, 15, 25, 32'h0003_0000, 32'hc0a0_8060, 1'b1);
        // Fog on after the discarded loads
        addRow(pixelPkg::REPLACE, 32'h3, 16, 26, 32'h0007_0000, 32'h4030_2010, 1'b0);
        addRow(pixelPkg::REPLACE, 32'h3, 17, 27, 32'h0019_0000, 32'h4030_2010, 1'b0);
        addRow(pixelPkg::REPLACE, 32'h3, 18, 28, 32'h03e8_0000, 32'h4030_2010, 1'b1);

        for (int i = 0; i < NUM_ROWS; i++)
        begin
            rows[i].expected = foggedColor(rows[i], texturedColor(rows[i]));
        end

        // Both outputs stay low during reset
        repeat (10)
        begin
            @(posedge aclk);
            #1;
            checkValue("fbValid", fbValid, 1'b0);
            checkValue("lutReady", lutReady, 1'b0);
        end
        reset = 1'b0;
        @(posedge aclk);
        #1;
        checkValue("lutReady", lutReady, 1'b1);
        checkOn = 1'b1;

        runRows(0, 8);

        for (int b = 0; b < pixelPkg::LUT_BEATS; b++)
        begin
            for (int i = 0; i < pixelPkg::FACTORS_PER_BEAT; i++)
            begin
                loadBeats[b][i * 8 +: 8] = goodTable[b * pixelPkg::FACTORS_PER_BEAT + i];
            end
        end
        sendLoad(4, 3);
        runRows(9, 14);

        // Fresh random data so that a wrong commit shows up
        for (int b = 0; b < 8; b++)
        begin
            loadBeats[b] = {$urandom, $urandom};
        end
        sendLoad(2, 1);
        sendLoad(5, 4);
        // Last lands on count 3 again, only the overflow flag rejects it
        sendLoad(8, 7);
        runRows(15, 17);

        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
design/pixelPkg.sv
design/beatCounter.sv
design/fogLutLoader.sv
design/fogTable.sv
design/texEnvUnit.sv
design/fogBlend.sv
design/delayLine.sv
design/pixelPipeline.sv
tb/fogLutLoader_properties.sv
tb/pixelPipelineTb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the pixel pipeline testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module pixelPipelineTb \
    -f build.f

./obj_dir/VpixelPipelineTb 2>&1 | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
